//--- Makefile
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -j 0
TOP := tb_rv_core
FILELIST := rv_core.f
MDIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)

run: build
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR) $(LOG)

//--- hdl/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu
	import rv_core_pkg::*;
(
	input wire logic [31:0] pc,
	input wire logic [31:0] src1,
	input wire logic [31:0] src2,
	input wire logic [31:0] imm,
	input wire alu_op_t alu_op,
	input wire logic src2_imm,
	input wire logic is_branch,
	input wire logic is_jal,
	input wire logic is_jalr,
	input wire logic is_auipc,
	input wire logic is_lui,
	input wire logic [2:0] funct3,
	output logic [31:0] alu_result,
	output logic [31:0] link_value,
	output logic [31:0] next_pc
);

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [4:0] shamt;
	logic [31:0] diff;
	logic taken;
	logic signed_ge;
	logic [31:0] jalr_target;

	always_comb begin
		if (is_auipc)
			op_a = pc;
		else if (is_lui)
			op_a = 32'b0; // result is just the upper imm
		else
			op_a = src1;
	end

	assign op_b = src2_imm ? imm : src2;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			alu_add: alu_result = op_a + op_b;
			alu_sub: alu_result = diff;
			alu_sll: alu_result = op_a << shamt;
			alu_srl: alu_result = op_a >> shamt;
			alu_sra: alu_result = $unsigned($signed(op_a) >>> shamt);
			alu_sltu: alu_result = {31'b0, op_a < op_b};
			alu_xor: alu_result = op_a ^ op_b;
			alu_or: alu_result = op_a | op_b;
			alu_and: alu_result = op_a & op_b;
			default: alu_result = op_b;
		endcase
	end

	// branch compare always on registers
	assign diff = src1 - src2;
	// signs differ means no overflow question
	assign signed_ge = (src1[31] ^ src2[31]) ? ~src1[31] : ~diff[31];

	always_comb begin
		case (funct3)
			3'b000: taken = (diff == 32'b0); // beq
			3'b001: taken = (diff != 32'b0); // bne
			3'b101: taken = signed_ge; // bge
			default: taken = 1'b0;
		endcase
	end

	assign link_value = pc + 32'd4;
	assign jalr_target = src1 + imm;

	always_comb begin
		if (is_jal || (is_branch && taken))
			next_pc = pc + imm;
		else if (is_jalr)
			next_pc = {jalr_target[31:1], 1'b0};
		else
			next_pc = link_value;
	end

	a_pc_aligned: assert final ($isunknown(pc) || (next_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- hdl/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu
	import rv_core_pkg::*;
(
	input wire instr_u instr,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [31:0] imm,
	output alu_op_t alu_op,
	output logic src2_imm,
	output logic reg_we,
	output logic mem_rd,
	output logic mem_we,
	output logic is_branch,
	output logic is_jal,
	output logic is_jalr,
	output logic is_auipc,
	output logic is_lui,
	output logic is_ebreak,
	output logic [2:0] funct3
);

	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] b_imm;
	logic [31:0] u_imm;
	logic [31:0] j_imm;
	logic [6:0] funct7;

	assign rs1 = instr.r.rs1;
	assign rs2 = instr.r.rs2;
	assign rd = instr.r.rd;
	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;

	assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign s_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
	assign b_imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
	assign u_imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
	assign j_imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11, instr.j.imm10_1, 1'b0};

	always_comb begin
		imm = 32'b0;
		alu_op = alu_pass_b;
		src2_imm = 1'b0;
		reg_we = 1'b0;
		mem_rd = 1'b0;
		mem_we = 1'b0;
		is_branch = 1'b0;
		is_jal = 1'b0;
		is_jalr = 1'b0;
		is_auipc = 1'b0;
		is_lui = 1'b0;
		is_ebreak = 1'b0;
		case (instr.r.opcode)
			op_lui, op_auipc: begin
				imm = u_imm;
				alu_op = alu_add;
				src2_imm = 1'b1;
				reg_we = 1'b1;
				is_lui = (instr.r.opcode == op_lui);
				is_auipc = (instr.r.opcode == op_auipc);
			end
			op_jal: begin
				imm = j_imm;
				reg_we = 1'b1;
				is_jal = 1'b1;
			end
			op_jalr: begin
				imm = i_imm;
				reg_we = (funct3 == 3'b000);
				is_jalr = (funct3 == 3'b000);
			end
			op_branch: begin
				imm = b_imm;
				alu_op = alu_sub;
				is_branch = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
			end
			op_load: begin
				imm = i_imm;
				alu_op = alu_add;
				src2_imm = 1'b1;
				mem_rd = (funct3 == 3'b010) || (funct3 == 3'b100); // lw, lbu
				reg_we = mem_rd;
			end
			op_store: begin
				imm = s_imm;
				alu_op = alu_add;
				src2_imm = 1'b1;
				mem_we = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
			end
			op_op_imm: begin
				imm = i_imm;
				src2_imm = 1'b1;
				reg_we = 1'b1;
				case (funct3)
					3'b000: alu_op = alu_add;
					3'b011: alu_op = alu_sltu; // compares against sign-extended imm
					3'b100: alu_op = alu_xor;
					3'b111: alu_op = alu_and;
					3'b001: begin
						alu_op = alu_sll;
						reg_we = (funct7 == 7'b0000000);
					end
					3'b101: begin
						alu_op = funct7[5] ? alu_sra : alu_srl;
						reg_we = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					end
					default: reg_we = 1'b0; // slti, ori
				endcase
			end
			op_op: begin
				reg_we = (funct7 == 7'b0000000);
				case (funct3)
					3'b000: alu_op = alu_add;
					3'b001: alu_op = alu_sll;
					3'b011: alu_op = alu_sltu;
					3'b100: alu_op = alu_xor;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					default: reg_we = 1'b0;
				endcase
			end
			op_system: begin
				is_ebreak = (instr.i.imm == 12'h001) && (rs1 == 5'd0) &&
					(funct3 == 3'b000) && (rd == 5'd0);
			end
			default: ;
		endcase
	end

	a_one_kind: assert final ($isunknown(instr) ||
		$onehot0({mem_rd, mem_we, is_branch, is_jal, is_jalr}));

endmodule

`default_nettype wire

//--- hdl/lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module lsu (
	input wire logic clk,
	input wire logic rst,
	input wire logic [31:0] addr,
	input wire logic [31:0] wdata,
	input wire logic mem_rd,
	input wire logic mem_we,
	input wire logic [2:0] funct3,
	output logic [31:0] load_data
);

	localparam int aw = $clog2(`DMEM_WORDS);

	logic [31:0] mem [0:`DMEM_WORDS-1];
	logic [aw-1:0] word_idx;
	logic [31:0] rword;
	logic [7:0] rbyte;
	logic [3:0] wmask;
	logic [31:0] wshift;

	assign word_idx = addr[aw+1:2];

	always_comb begin
		case (funct3[1:0])
			2'b00: begin // sb
				wmask = 4'b0001 << addr[1:0];
				wshift = {4{wdata[7:0]}};
			end
			2'b01: begin // sh
				wmask = 4'b0011 << {addr[1], 1'b0};
				wshift = {2{wdata[15:0]}};
			end
			2'b10: begin
				wmask = 4'b1111;
				wshift = wdata;
			end
			default: begin
				wmask = 4'b0000;
				wshift = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst && mem_we) begin
			for (int b = 0; b < 4; b++) begin
				if (wmask[b])
					mem[word_idx][8*b +: 8] <= wshift[8*b +: 8];
			end
		end
	end

	assign rword = mem[word_idx];
	assign rbyte = rword[8*addr[1:0] +: 8];

	always_comb begin
		if (!mem_rd)
			load_data = 32'b0;
		else if (funct3 == 3'b100)
			load_data = {24'b0, rbyte}; // lbu
		else
			load_data = rword;
	end

	a_aligned: assert property (@(posedge clk) disable iff (rst)
		(mem_rd || mem_we) |->
		((funct3[1:0] == 2'b10) ? (addr[1:0] == 2'b00) :
		(funct3[1:0] == 2'b01) ? (addr[0] == 1'b0) : 1'b1));

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile #(
	parameter int num_regs = 32
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [4:0] rs1,
	input wire logic [4:0] rs2,
	input wire logic [4:0] rd,
	input wire logic we,
	input wire logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [0:num_regs-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < num_regs; r++)
				regs[r] <= 32'b0;
		end
		else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads zero
	assign rdata1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core
	import rv_core_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	output logic [31:0] imem_addr,
	input wire logic [31:0] imem_data,
	output logic retire,
	output logic wb_en,
	output logic [4:0] wb_rd,
	output logic [31:0] wb_data,
	output logic halted
);

	logic [31:0] pc;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [31:0] imm;
	alu_op_t alu_op;
	logic src2_imm;
	logic reg_we;
	logic mem_rd;
	logic mem_we;
	logic is_branch;
	logic is_jal;
	logic is_jalr;
	logic is_auipc;
	logic is_lui;
	logic is_ebreak;
	logic [2:0] funct3;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] alu_result;
	logic [31:0] link_value;
	logic [31:0] next_pc;
	logic [31:0] load_data;
	logic run;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
			halted <= 1'b0;
		end
		else if (!halted) begin
			if (is_ebreak)
				halted <= 1'b1; // pc stays on the ebreak
			else
				pc <= next_pc;
		end
	end

	assign run = !halted && !rst;
	assign imem_addr = pc;
	assign retire = run;
	assign wb_en = run && reg_we && (wb_rd != 5'd0);

	always_comb begin
		if (mem_rd)
			wb_data = load_data;
		else if (is_jal || is_jalr)
			wb_data = link_value;
		else
			wb_data = alu_result;
	end

	idu idu_i (
		.instr(instr_u'(imem_data)),
		.rs1(rs1),
		.rs2(rs2),
		.rd(wb_rd),
		.imm(imm),
		.alu_op(alu_op),
		.src2_imm(src2_imm),
		.reg_we(reg_we),
		.mem_rd(mem_rd),
		.mem_we(mem_we),
		.is_branch(is_branch),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_auipc(is_auipc),
		.is_lui(is_lui),
		.is_ebreak(is_ebreak),
		.funct3(funct3)
	);

	regfile #(
		.num_regs(`NUM_REGS)
	) regfile_i (
		.clk(clk),
		.rst(rst),
		.rs1(rs1),
		.rs2(rs2),
		.rd(wb_rd),
		.we(wb_en),
		.wdata(wb_data),
		.rdata1(src1),
		.rdata2(src2)
	);

	exu exu_i (
		.pc(pc),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.alu_op(alu_op),
		.src2_imm(src2_imm),
		.is_branch(is_branch),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_auipc(is_auipc),
		.is_lui(is_lui),
		.funct3(funct3),
		.alu_result(alu_result),
		.link_value(link_value),
		.next_pc(next_pc)
	);

	lsu lsu_i (
		.clk(clk),
		.rst(rst),
		.addr(alu_result),
		.wdata(src2),
		.mem_rd(mem_rd),
		.mem_we(mem_we && !halted),
		.funct3(funct3),
		.load_data(load_data)
	);

	// halt only ever follows a fetched ebreak
	a_halt_cause: assert property (@(posedge clk) disable iff (rst)
		$rose(halted) |-> ($past(imem_data) == `EBREAK_WORD));

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	typedef enum logic [6:0] {
		op_lui = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal = 7'b1101111,
		op_jalr = 7'b1100111,
		op_branch = 7'b1100011,
		op_load = 7'b0000011,
		op_store = 7'b0100011,
		op_op_imm = 7'b0010011,
		op_op = 7'b0110011,
		op_system = 7'b1110011
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_sltu,
		alu_xor,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t opcode;
	} i_view_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_t opcode;
	} s_view_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		opcode_t opcode;
	} b_view_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_t opcode;
	} j_view_t;

	// one fetched word, read through each format
	typedef union packed {
		r_view_t r;
		i_view_t i;
		s_view_t s;
		b_view_t b;
		j_view_t j;
	} instr_u;

endpackage

`default_nettype wire

//--- include/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// pc after reset
`define RESET_PC 32'h0000_0000

`define NUM_REGS 32

// data memory depth in words
`define DMEM_WORDS 256

`define EBREAK_WORD 32'h0010_0073

`endif

//--- rv_core.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/idu.sv
hdl/exu.sv
hdl/lsu.sv
hdl/regfile.sv
hdl/rv_core.sv
verification/tb_rv_core_checks.sv
verification/tb_rv_core.sv

//--- verification/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core
	import rv_core_pkg::*;
();

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic retire;
	logic wb_en;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;
	logic halted;

	logic [31:0] rom [0:255];
	int pc_idx = 0;
	int test_end [0:4];
	string test_name [0:5] = '{"alu", "upper immediate", "load store", "branch", "jump", "halt"};
	integer seed = 32'h5868ace2;
	logic [31:0] r1;
	logic [31:0] r2;
	logic [31:0] r3;
	bit prog_ready = 1'b0;
	int test_fails = 0;
	int seen_errors = 0;

	always #10 clk = ~clk;

	assign imem_data = rom[imem_addr[9:2]]; // combinational fetch

	rv_core rv_core_i (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.retire(retire),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.halted(halted)
	);

	bind rv_core tb_rv_core_checks checks_i (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.retire(retire),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.halted(halted)
	);

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_op};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	task automatic put(input logic [31:0] word);
		rom[pc_idx] = word;
		pc_idx++;
	endtask

	// lui plus addi, upper part rounded for the sign of the low 12 bits
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		put(u_type(upper[31:12], rd, op_lui));
		put(i_type(value[11:0], rd, 3'b000, rd, op_op_imm));
	endtask

	// slot that a taken branch or jump steps over
	task automatic skip_slot();
		put(i_type(12'd1, 5'd25, 3'b000, 5'd25, op_op_imm));
	endtask

	task automatic branch_over(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		put(b_type(13'd8, rs2, rs1, f3));
		skip_slot();
	endtask

	task automatic wait_for_pc(input int word_idx);
		while (imem_addr < 32'(word_idx * 4) && !halted)
			@(negedge clk);
	endtask

	task automatic finish_test(input int t);
		int now_errors;
		now_errors = rv_core_i.checks_i.errors;
		if (now_errors != seen_errors)
			test_fails++;
		$display("test %0d %s: %s, %0d failed checks", t + 1, test_name[t],
			(now_errors != seen_errors) ? "failed" : "passed", now_errors - seen_errors);
		seen_errors = now_errors;
	endtask

	initial begin
		for (int i = 0; i < 256; i++)
			rom[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, op_op_imm); // addi x0, x0, index
		r1 = $random(seed) & 32'h7fff_ffff;
		r2 = $random(seed) | 32'h8000_0080; // negative, low byte above 0x7f
		r3 = $random(seed);
		load_const(5'd1, r1);
		load_const(5'd2, r2);
		load_const(5'd3, r3);
		put(i_type(r3[31:20], 5'd1, 3'b000, 5'd4, op_op_imm));
		put(i_type(12'hfff, 5'd1, 3'b011, 5'd5, op_op_imm)); // sltiu against all ones
		put(i_type(12'h5a5, 5'd2, 3'b100, 5'd6, op_op_imm));
		put(i_type(12'h0f0, 5'd1, 3'b111, 5'd7, op_op_imm));
		put(i_type({7'b0000000, r3[4:0]}, 5'd1, 3'b001, 5'd8, op_op_imm));
		put(i_type({7'b0000000, 5'd9}, 5'd2, 3'b101, 5'd9, op_op_imm));
		put(i_type({7'b0100000, 5'd9}, 5'd2, 3'b101, 5'd10, op_op_imm)); // srai on negative
		put(r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd11));
		put(r_type(7'd0, 5'd3, 5'd1, 3'b001, 5'd12));
		put(r_type(7'd0, 5'd2, 5'd1, 3'b011, 5'd13));
		put(r_type(7'd0, 5'd1, 5'd2, 3'b011, 5'd14));
		put(r_type(7'd0, 5'd2, 5'd1, 3'b100, 5'd15));
		put(r_type(7'd0, 5'd2, 5'd1, 3'b110, 5'd16));
		put(r_type(7'd0, 5'd2, 5'd1, 3'b111, 5'd17));
		test_end[0] = pc_idx;
		r3 = $random(seed);
		put(u_type(r3[19:0], 5'd18, op_lui));
		put(u_type(r3[31:12], 5'd19, op_auipc));
		test_end[1] = pc_idx;
		load_const(5'd20, 32'h0000_0100);
		put(s_type(12'd0, 5'd1, 5'd20, 3'b010));
		put(s_type(12'd4, 5'd2, 5'd20, 3'b010));
		put(s_type(12'd6, 5'd1, 5'd20, 3'b001));
		put(s_type(12'd1, 5'd2, 5'd20, 3'b000));
		put(s_type(12'd3, 5'd3, 5'd20, 3'b000));
		put(i_type(12'd0, 5'd20, 3'b010, 5'd21, op_load));
		put(i_type(12'd4, 5'd20, 3'b010, 5'd22, op_load));
		put(i_type(12'd1, 5'd20, 3'b100, 5'd23, op_load));
		put(i_type(12'd7, 5'd20, 3'b100, 5'd24, op_load));
		test_end[2] = pc_idx;
		branch_over(3'b000, 5'd1, 5'd1);
		branch_over(3'b000, 5'd1, 5'd2);
		branch_over(3'b001, 5'd1, 5'd2);
		branch_over(3'b001, 5'd1, 5'd1);
		branch_over(3'b101, 5'd1, 5'd2); // positive against negative
		branch_over(3'b101, 5'd2, 5'd1);
		branch_over(3'b101, 5'd1, 5'd1);
		test_end[3] = pc_idx;
		put(j_type(21'd8, 5'd26));
		skip_slot();
		put(j_type(21'd8, 5'd0));
		skip_slot();
		put(u_type(20'd0, 5'd27, op_auipc));
		put(i_type(12'd13, 5'd27, 3'b000, 5'd28, op_jalr)); // odd target, bit 0 dropped
		skip_slot();
		put(u_type(20'd0, 5'd27, op_auipc));
		put(i_type(12'd12, 5'd27, 3'b000, 5'd0, op_jalr));
		skip_slot();
		test_end[4] = pc_idx;
		put(`EBREAK_WORD);
		skip_slot();
		skip_slot();
		prog_ready = 1'b1;

		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int t = 0; t < 5; t++) begin
			wait_for_pc(test_end[t]);
			finish_test(t);
		end
		while (!halted)
			@(negedge clk);
		repeat (20) @(negedge clk);
		finish_test(5);
		$display("tests run 6, tests failed %0d, failed checks %0d", test_fails, seen_errors);
		if (test_fails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// program length plus reset plus slack for the idle cycles after halt
	initial begin
		wait (prog_ready);
		#((pc_idx + 16 + 64) * 20);
		$display("timeout: core did not halt and settle within %0d cycles", pc_idx + 16 + 64);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_rv_core_checks.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core_checks
	import rv_core_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic [31:0] imem_addr,
	input wire logic [31:0] imem_data,
	input wire logic retire,
	input wire logic wb_en,
	input wire logic [4:0] wb_rd,
	input wire logic [31:0] wb_data,
	input wire logic halted
);

	int errors = 0;

	logic [31:0] model_pc;
	logic model_halted;
	logic [31:0] model_regs [0:`NUM_REGS-1];
	logic [7:0] model_mem [0:4*`DMEM_WORDS-1]; // byte wide copy of dmem

	logic [6:0] opc;
	logic [4:0] rd;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] ld_addr;
	logic [31:0] st_addr;
	logic [31:0] ld_word;
	logic [31:0] exp_data;
	logic [31:0] exp_pc;
	logic exp_we;

	assign opc = imem_data[6:0];
	assign rd = imem_data[11:7];
	assign f3 = imem_data[14:12];
	assign f7 = imem_data[31:25];
	assign src_a = model_regs[imem_data[19:15]];
	assign src_b = model_regs[imem_data[24:20]];

	assign imm_i = {{20{imem_data[31]}}, imem_data[31:20]};
	assign imm_s = {{20{imem_data[31]}}, imem_data[31:25], imem_data[11:7]};
	assign imm_b = {{19{imem_data[31]}}, imem_data[31], imem_data[7], imem_data[30:25],
		imem_data[11:8], 1'b0};
	assign imm_u = {imem_data[31:12], 12'b0};
	assign imm_j = {{11{imem_data[31]}}, imem_data[31], imem_data[19:12], imem_data[20],
		imem_data[30:21], 1'b0};

	assign ld_addr = src_a + imm_i;
	assign st_addr = src_a + imm_s;
	assign ld_word = {model_mem[{ld_addr[9:2], 2'b11}], model_mem[{ld_addr[9:2], 2'b10}],
		model_mem[{ld_addr[9:2], 2'b01}], model_mem[{ld_addr[9:2], 2'b00}]};

	// expected result of the word being fetched
	always_comb begin
		exp_we = 1'b0;
		exp_data = 32'b0;
		exp_pc = model_pc + 32'd4;
		case (opc)
			op_lui: begin
				exp_we = 1'b1;
				exp_data = imm_u;
			end
			op_auipc: begin
				exp_we = 1'b1;
				exp_data = model_pc + imm_u;
			end
			op_jal: begin
				exp_we = 1'b1;
				exp_data = model_pc + 32'd4;
				exp_pc = model_pc + imm_j;
			end
			op_jalr: begin
				exp_we = 1'b1;
				exp_data = model_pc + 32'd4;
				exp_pc = (src_a + imm_i) & ~32'd1;
			end
			op_branch: begin
				if ((f3 == 3'b000 && src_a == src_b) || (f3 == 3'b001 && src_a != src_b) ||
						(f3 == 3'b101 && $signed(src_a) >= $signed(src_b)))
					exp_pc = model_pc + imm_b;
			end
			op_load: begin
				exp_we = 1'b1;
				exp_data = (f3 == 3'b100) ? {24'b0, model_mem[ld_addr[9:0]]} : ld_word;
			end
			op_op_imm: begin
				exp_we = 1'b1;
				case (f3)
					3'b000: exp_data = src_a + imm_i;
					3'b011: exp_data = {31'b0, src_a < imm_i};
					3'b100: exp_data = src_a ^ imm_i;
					3'b111: exp_data = src_a & imm_i;
					3'b001: exp_data = src_a << imm_i[4:0];
					default: begin
						if (f7[5])
							exp_data = $signed(src_a) >>> imm_i[4:0];
						else
							exp_data = src_a >> imm_i[4:0];
					end
				endcase
			end
			op_op: begin
				exp_we = 1'b1;
				case (f3)
					3'b000: exp_data = src_a + src_b;
					3'b001: exp_data = src_a << src_b[4:0];
					3'b011: exp_data = {31'b0, src_a < src_b};
					3'b100: exp_data = src_a ^ src_b;
					3'b110: exp_data = src_a | src_b;
					default: exp_data = src_a & src_b;
				endcase
			end
			default: begin
				if (imem_data == `EBREAK_WORD)
					exp_pc = model_pc; // halts on itself
			end
		endcase
		if (rd == 5'd0)
			exp_we = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			model_pc <= `RESET_PC;
			model_halted <= 1'b0;
			for (int r = 0; r < `NUM_REGS; r++)
				model_regs[r] <= 32'b0;
		end
		else if (!model_halted) begin
			model_pc <= exp_pc;
			if (imem_data == `EBREAK_WORD)
				model_halted <= 1'b1;
			if (exp_we)
				model_regs[rd] <= exp_data;
			if (opc == op_store) begin
				model_mem[st_addr[9:0]] <= src_b[7:0];
				if (f3 != 3'b000)
					model_mem[st_addr[9:0] + 10'd1] <= src_b[15:8];
				if (f3 == 3'b010) begin
					model_mem[st_addr[9:0] + 10'd2] <= src_b[23:16];
					model_mem[st_addr[9:0] + 10'd3] <= src_b[31:24];
				end
			end
		end
	end

	a_pc: assert property (@(posedge clk) disable iff (rst) imem_addr == model_pc)
		else begin
			$error("FAIL imem_addr expected %h actual %h", $sampled(model_pc),
				$sampled(imem_addr));
			errors++;
		end

	a_wb_en: assert property (@(posedge clk) disable iff (rst)
		wb_en == (exp_we && !model_halted))
		else begin
			$error("FAIL wb_en expected %h actual %h", $sampled(exp_we && !model_halted),
				$sampled(wb_en));
			errors++;
		end

	a_wb_rd: assert property (@(posedge clk) disable iff (rst)
		(retire && exp_we) |-> wb_rd == rd)
		else begin
			$error("FAIL wb_rd expected %h actual %h", $sampled(rd), $sampled(wb_rd));
			errors++;
		end

	a_wb_data: assert property (@(posedge clk) disable iff (rst)
		(retire && exp_we) |-> wb_data == exp_data)
		else begin
			$error("FAIL wb_data x%0d expected %h actual %h", $sampled(wb_rd),
				$sampled(exp_data), $sampled(wb_data));
			errors++;
		end

	a_halted: assert property (@(posedge clk) disable iff (rst) halted == model_halted)
		else begin
			$error("FAIL halted expected %h actual %h", $sampled(model_halted),
				$sampled(halted));
			errors++;
		end

	// no retire once stopped
	a_retire: assert property (@(posedge clk) disable iff (rst) retire == !model_halted)
		else begin
			$error("FAIL retire expected %h actual %h", $sampled(!model_halted),
				$sampled(retire));
			errors++;
		end

endmodule

`default_nettype wire
